/* rtl/cacheCtrl.sv */
`timescale 1ns/1ps

module cacheCtrl #(
  parameter int numSets = 64
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [cachePkg::addrWidth-1:0] addr_i,
  input  logic                           valid_i,
  output logic                           addrOk_o,
  output logic                           dataOk_o,
  lookupIf.ctrl                          lookup,
  refillIf.ctrl                          refill
);
  import cachePkg::*;

  localparam int indexWidth = $clog2(numSets);
  localparam int tagWidth = addrWidth - indexWidth - offsetWidth;
  localparam int wordSelWidth = $clog2(beatsPerLine);

  cacheStateE                 state;
  cacheStateE                 nextState;
  logic [addrWidth-1:0]       reqAddr;
  logic [$clog2(numWays)-1:0] missWay;
  logic                       hit;
  logic                       accept;

  assign hit = lookup.hitWay0 | lookup.hitWay1;

  // new request allowed when idle or while the current one hits
  assign addrOk_o = (state == stIdle) || ((state == stCompare) && hit);
  assign dataOk_o = (state == stCompare) && hit;
  assign accept = valid_i && addrOk_o;

  always_comb begin
    nextState = state;
    case (state)
      stIdle: begin
        if (valid_i) begin
          nextState = stCompare;
        end
      end
      stCompare: begin
        if (!hit) begin
          nextState = stMiss;
        end else if (!valid_i) begin
          nextState = stIdle;
        end
      end
      stMiss: begin
        nextState = stRefill;
      end
      stRefill: begin
        if (refill.done) begin
          nextState = stReplay;
        end
      end
      stReplay: begin
        nextState = stCompare;
      end
      default: begin
        nextState = stIdle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= stIdle;
      missWay <= '0;
    end else begin
      state <= nextState;
      // remember where the missing line goes
      if ((state == stCompare) && !hit) begin
        missWay <= lookup.victimWay;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      reqAddr <= addr_i;
    end
  end

  // arrays read the incoming index on accept, the held one on replay
  assign lookup.lookupEn = accept || (state == stReplay);
  assign lookup.index = accept ? addr_i[offsetWidth +: indexWidth]
                               : reqAddr[offsetWidth +: indexWidth];
  assign lookup.tag = reqAddr[addrWidth-1 -: tagWidth];
  assign lookup.wordSel = reqAddr[offsetWidth-1 -: wordSelWidth];

  assign refill.start = (state == stMiss);
  assign refill.lineAddr = {reqAddr[addrWidth-1:offsetWidth], {offsetWidth{1'b0}}};
  assign refill.way = missWay;

endmodule

/* rtl/cachePkg.sv */
package cachePkg;

  // request and data widths
  localparam int addrWidth = 32;
  localparam int xlen = 64;

  // line geometry, 32-byte lines fetched in four beats
  localparam int offsetWidth = 5;
  localparam int beatsPerLine = 4;
  localparam int lineWidth = xlen * beatsPerLine;

  // victim choice and hit encoding assume two ways
  localparam int numWays = 2;

  // controller states
  typedef enum logic [2:0] {
    stIdle,
    stCompare,
    stMiss,
    stRefill,
    stReplay
  } cacheStateE;

endpackage

/* rtl/cacheTop.sv */
`timescale 1ns/1ps

module cacheTop #(
  parameter int numSets = 64
) (
  input  logic                           clk,
  input  logic                           rst_n,

  // pipeline side
  input  logic [cachePkg::addrWidth-1:0] addr_i,
  input  logic                           valid_i,
  output logic                           addrOk_o,
  output logic                           dataOk_o,
  output logic [cachePkg::xlen-1:0]      rdData_o,

  // memory side
  output logic                           memRdReq_o,
  output logic [cachePkg::addrWidth-1:0] memAddr_o,
  input  logic                           memRdAck_i,
  input  logic                           memRdValid_i,
  input  logic                           memRdLast_i,
  input  logic [cachePkg::xlen-1:0]      memRdData_i
);

  lookupIf #(.numSets(numSets)) lookupBus ();
  refillIf refillBus ();

  cacheCtrl #(
    .numSets(numSets)
  ) cacheCtrl_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .addr_i   (addr_i),
    .valid_i  (valid_i),
    .addrOk_o (addrOk_o),
    .dataOk_o (dataOk_o),
    .lookup   (lookupBus.ctrl),
    .refill   (refillBus.ctrl)
  );

  tagValidArray #(
    .numSets(numSets)
  ) tagValidArray_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .lookup (lookupBus.array),
    .refill (refillBus.array)
  );

  dataArray #(
    .numSets(numSets)
  ) dataArray_inst (
    .clk      (clk),
    .lookup   (lookupBus.array),
    .refill   (refillBus.array),
    .rdData_o (rdData_o)
  );

  refillUnit refillUnit_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .memRdAck_i   (memRdAck_i),
    .memRdValid_i (memRdValid_i),
    .memRdLast_i  (memRdLast_i),
    .memRdData_i  (memRdData_i),
    .memRdReq_o   (memRdReq_o),
    .memAddr_o    (memAddr_o),
    .refill       (refillBus.refill)
  );

endmodule

/* rtl/dataArray.sv */
`timescale 1ns/1ps

module dataArray #(
  parameter int numSets = 64
) (
  input  logic                      clk,
  lookupIf.array                    lookup,
  refillIf.array                    refill,
  output logic [cachePkg::xlen-1:0] rdData_o
);
  import cachePkg::*;

  // one full line per way and set
  logic [lineWidth-1:0] lineMem [numWays][numSets];

  // lines of the looked-up set, one per way
  logic [lineWidth-1:0] lineQ [numWays];
  logic [lineWidth-1:0] hitLine;

  always_ff @(posedge clk) begin
    // refill writes the whole line at once
    if (refill.done) begin
      lineMem[refill.way][lookup.index] <= refill.lineData;
    end
    if (lookup.lookupEn) begin
      for (int w = 0; w < numWays; w++) begin
        lineQ[w] <= lineMem[w][lookup.index];
      end
    end
  end

  // way 0 when it hits, otherwise way 1
  // only meaningful while dataOk is high
  assign hitLine = lookup.hitWay0 ? lineQ[0] : lineQ[1];

  // word select comes from address bits 4:3
  assign rdData_o = hitLine[lookup.wordSel * xlen +: xlen];

endmodule

/* rtl/lookupIf.sv */
`timescale 1ns/1ps

interface lookupIf #(
  parameter int numSets = 64
) ();
  import cachePkg::*;

  localparam int indexWidth = $clog2(numSets);
  localparam int tagWidth = addrWidth - indexWidth - offsetWidth;
  localparam int wordSelWidth = $clog2(beatsPerLine);

  // request side, driven by the controller
  logic                       lookupEn;
  logic [indexWidth-1:0]      index;
  logic [tagWidth-1:0]        tag;
  logic [wordSelWidth-1:0]    wordSel;

  // result side, valid the cycle after lookupEn
  logic                       hitWay0;
  logic                       hitWay1;
  logic [$clog2(numWays)-1:0] victimWay;

  modport ctrl (
    output lookupEn, index, tag, wordSel,
    input  hitWay0, hitWay1, victimWay
  );

  modport array (
    input  lookupEn, index, tag, wordSel,
    output hitWay0, hitWay1, victimWay
  );

endinterface

/* rtl/refillIf.sv */
`timescale 1ns/1ps

interface refillIf;
  import cachePkg::*;

  // one-cycle pulse that kicks off a line fetch
  logic                       start;
  logic [addrWidth-1:0]       lineAddr;
  // way that receives the line
  logic [$clog2(numWays)-1:0] way;

  // one-cycle pulse, line is written in this cycle
  logic                       done;
  logic [lineWidth-1:0]       lineData;

  modport refill (
    input  start, lineAddr,
    output done, lineData
  );

  modport array (
    input done, lineData, way
  );

  modport ctrl (
    output start, lineAddr, way,
    input  done
  );

endinterface

/* rtl/refillUnit.sv */
`timescale 1ns/1ps

module refillUnit (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           memRdAck_i,
  input  logic                           memRdValid_i,
  input  logic                           memRdLast_i,
  input  logic [cachePkg::xlen-1:0]      memRdData_i,
  output logic                           memRdReq_o,
  output logic [cachePkg::addrWidth-1:0] memAddr_o,
  refillIf.refill                        refill
);
  import cachePkg::*;

  localparam int beatWidth = $clog2(beatsPerLine);

  logic                 busy;
  logic                 ackSeen;
  logic                 beatTake;
  logic [beatWidth-1:0] beatCnt;
  logic [lineWidth-1:0] lineBuf;
  logic                 doneQ;

  assign ackSeen = memRdReq_o && memRdAck_i;
  // beats may start in the acknowledge cycle
  assign beatTake = (busy || ackSeen) && memRdValid_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      memRdReq_o <= 1'b0;
      busy <= 1'b0;
      beatCnt <= '0;
      doneQ <= 1'b0;
    end else begin
      doneQ <= beatTake && memRdLast_i;
      // request held until memory acknowledges
      if (refill.start) begin
        memRdReq_o <= 1'b1;
      end else if (ackSeen) begin
        memRdReq_o <= 1'b0;
      end
      if (ackSeen) begin
        busy <= 1'b1;
      end
      if (beatTake && memRdLast_i) begin
        busy <= 1'b0;
      end
      if (refill.start) begin
        beatCnt <= '0;
      end else if (beatTake) begin
        beatCnt <= beatCnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (refill.start) begin
      memAddr_o <= refill.lineAddr;
    end
    // each beat lands at its own word position
    if (beatTake) begin
      lineBuf[beatCnt * xlen +: xlen] <= memRdData_i;
    end
  end

  assign refill.done = doneQ;
  assign refill.lineData = lineBuf;

endmodule

/* rtl/tagValidArray.sv */
`timescale 1ns/1ps

module tagValidArray #(
  parameter int numSets = 64
) (
  input  logic    clk,
  input  logic    rst_n,
  lookupIf.array  lookup,
  refillIf.array  refill
);
  import cachePkg::*;

  localparam int indexWidth = $clog2(numSets);
  localparam int tagWidth = addrWidth - indexWidth - offsetWidth;

  logic [tagWidth-1:0]             tagMem [numWays][numSets];
  logic [numWays-1:0][numSets-1:0] validMem;

  // copies of the looked-up set
  logic [tagWidth-1:0]             tagQ [numWays];
  logic [numWays-1:0]              validQ;

  // replacement source when both ways are valid
  logic [7:0]                      lfsr;

  always_ff @(posedge clk) begin
    if (refill.done) begin
      tagMem[refill.way][lookup.index] <= lookup.tag;
    end
    if (lookup.lookupEn) begin
      for (int w = 0; w < numWays; w++) begin
        tagQ[w] <= tagMem[w][lookup.index];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validMem <= '0;
      validQ <= '0;
      lfsr <= 8'hA5;
    end else begin
      if (refill.done) begin
        validMem[refill.way][lookup.index] <= 1'b1;
        // taps 8,6,5,4
        lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
      end
      if (lookup.lookupEn) begin
        for (int w = 0; w < numWays; w++) begin
          validQ[w] <= validMem[w][lookup.index];
        end
      end
    end
  end

  // compare against the tag of the request now in compare
  assign lookup.hitWay0 = validQ[0] && (tagQ[0] == lookup.tag);
  assign lookup.hitWay1 = validQ[1] && (tagQ[1] == lookup.tag);

  // fill empty ways first
  always_comb begin
    if (!validQ[0]) begin
      lookup.victimWay = 1'b0;
    end else if (!validQ[1]) begin
      lookup.victimWay = 1'b1;
    end else begin
      lookup.victimWay = lfsr[0];
    end
  end

endmodule

/* run.sh */
#!/bin/sh
# build and run the instruction cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module cacheTb -f src.f -o cacheSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

simOut=$(./obj_dir/cacheSim)
simStatus=$?
printf '%s\n' "$simOut"
if [ $simStatus -ne 0 ]; then
  echo "simulation returned an error status"
  exit 1
fi

if printf '%s\n' "$simOut" | grep -qx "sim passed"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* src.f */
rtl/cachePkg.sv
rtl/lookupIf.sv
rtl/refillIf.sv
rtl/cacheCtrl.sv
rtl/tagValidArray.sv
rtl/dataArray.sv
rtl/refillUnit.sv
rtl/cacheTop.sv
test/memModel.sv
test/cacheTb.sv

/* test/cacheTb.sv */
`timescale 1ns/1ps

module cacheTb;
  import cachePkg::*;

  localparam int halfPeriod = 2;
  localparam int resetCycles = 4;
  localparam int acceptTimeout = 50;
  localparam int responseTimeout = 200;
  localparam logic [31:0] lowPattern = 32'hC3A5_5A3C;

  // expected miss flag of a row
  localparam logic [1:0] expHit = 2'd0;
  localparam logic [1:0] expMiss = 2'd1;
  localparam logic [1:0] dontCare = 2'd2;

  typedef struct packed {
    logic [addrWidth-1:0] addr;
    logic [1:0]           missExp;
    logic                 chain;
  } stimRow;

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic [addrWidth-1:0] addr;
  logic                 valid;
  logic                 addrOk;
  logic                 dataOk;
  logic [xlen-1:0]      rdData;
  logic                 memRdReq;
  logic [addrWidth-1:0] memAddr;
  logic                 memRdAck;
  logic                 memRdValid;
  logic                 memRdLast;
  logic [xlen-1:0]      memRdData;

  stimRow               stimTable [$];
  int                   reqCount = 0;
  logic                 reqPrev = 1'b0;
  logic [addrWidth-1:0] reqAddrSeen;

  cacheTop #(.numSets(64)) cacheTop_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .addr_i       (addr),
    .valid_i      (valid),
    .addrOk_o     (addrOk),
    .dataOk_o     (dataOk),
    .rdData_o     (rdData),
    .memRdReq_o   (memRdReq),
    .memAddr_o    (memAddr),
    .memRdAck_i   (memRdAck),
    .memRdValid_i (memRdValid),
    .memRdLast_i  (memRdLast),
    .memRdData_i  (memRdData)
  );

  memModel memModel_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .memRdReq_i   (memRdReq),
    .memAddr_i    (memAddr),
    .memRdAck_o   (memRdAck),
    .memRdValid_o (memRdValid),
    .memRdLast_o  (memRdLast),
    .memRdData_o  (memRdData)
  );

  always #halfPeriod clk = ~clk;

  // count memory requests at mid-cycle
  always @(negedge clk) begin
    if (memRdReq && !reqPrev) begin
      reqCount = reqCount + 1;
      reqAddrSeen = memAddr;
    end
    reqPrev = memRdReq;
  end

  function automatic logic [xlen-1:0] expectedWord(input logic [addrWidth-1:0] a);
    logic [addrWidth-1:0] wordAddr;
    wordAddr = {a[addrWidth-1:3], 3'b000};
    return {wordAddr, wordAddr ^ lowPattern};
  endfunction

  task automatic checkData(input string label, input logic [xlen-1:0] got,
                           input logic [xlen-1:0] exp);
    if (got !== exp) begin
      $display("FAILED %0t: %s got %h expected %h", $time, label, got, exp);
      $display("sim failed");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic checkAddr(input string label, input logic [addrWidth-1:0] got,
                           input logic [addrWidth-1:0] exp);
    if (got !== exp) begin
      $display("FAILED %0t: %s got %h expected %h", $time, label, got, exp);
      $display("sim failed");
      $fatal(1, "address mismatch");
    end
  endtask

  task automatic checkFlag(input string label, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED %0t: %s got %b expected %b", $time, label, got, exp);
      $display("sim failed");
      $fatal(1, "flag mismatch");
    end
  endtask

  task automatic timeoutFail(input string what);
    $display("timed out waiting for %s", what);
    $display("sim failed");
    $fatal(1, "timeout");
  endtask

  task automatic nextCycle();
    @(posedge clk);
    #1;
  endtask

  task automatic waitAddrOk(output int waited);
    waited = 0;
    while (!addrOk && waited < acceptTimeout) begin
      nextCycle();
      waited++;
    end
    if (!addrOk) timeoutFail("addrOk_o");
  endtask

  task automatic waitDataOk(output int waited);
    waited = 0;
    while (!dataOk && waited < responseTimeout) begin
      nextCycle();
      waited++;
    end
    if (!dataOk) timeoutFail("dataOk_o");
  endtask

  task automatic addRow(input logic [addrWidth-1:0] a, input logic [1:0] m, input logic c);
    stimRow r;
    r.addr = a;
    r.missExp = m;
    r.chain = c;
    stimTable.push_back(r);
  endtask

  initial begin
    stimRow row;
    int addrWaited;
    int dataWaited;
    int reqBefore;
    logic missed;
    logic prevChain;

    rst_n = 1'b0;
    valid = 1'b0;
    addr = '0;

    // first touch misses and the rest of the line hits
    addRow(32'h0000_1040, expMiss, 1'b0);
    addRow(32'h0000_1048, expHit, 1'b0);
    addRow(32'h0000_1050, expHit, 1'b0);
    addRow(32'h0000_1058, expHit, 1'b0);
    // two tags in set 5
    addRow(32'h0000_40A0, expMiss, 1'b0);
    addRow(32'h0000_48A8, expMiss, 1'b0);
    addRow(32'h0000_40B0, expHit, 1'b0);
    addRow(32'h0000_48B8, expHit, 1'b0);
    // a third tag there evicts one way
    addRow(32'h0000_50A0, expMiss, 1'b0);
    addRow(32'h0000_40A8, dontCare, 1'b0);
    addRow(32'h0000_48A0, dontCare, 1'b0);
    addRow(32'h0000_50B8, dontCare, 1'b0);
    // new line in set 0, then hits with valid held high
    addRow(32'h8000_0010, expMiss, 1'b0);
    addRow(32'h0000_1058, expHit, 1'b1);
    addRow(32'h8000_0000, expHit, 1'b1);
    addRow(32'h0000_1040, expHit, 1'b1);
    addRow(32'h8000_0018, expHit, 1'b1);
    addRow(32'h0000_1050, expHit, 1'b0);

    repeat (resetCycles) @(posedge clk);
    #1;
    rst_n = 1'b1;
    nextCycle();
    checkFlag("addrOk_o after reset", addrOk, 1'b1);
    checkFlag("dataOk_o after reset", dataOk, 1'b0);
    checkFlag("memRdReq_o after reset", memRdReq, 1'b0);

    prevChain = 1'b0;
    foreach (stimTable[i]) begin
      row = stimTable[i];
      reqBefore = reqCount;
      valid = 1'b1;
      addr = row.addr;
      waitAddrOk(addrWaited);
      if (prevChain) checkFlag("back-to-back accept", addrWaited == 0, 1'b1);
      nextCycle();
      if (!row.chain) valid = 1'b0;
      waitDataOk(dataWaited);
      checkData($sformatf("rdData_o for %h", row.addr), rdData, expectedWord(row.addr));
      missed = (reqCount != reqBefore);
      checkFlag("at most one memory request", (reqCount - reqBefore) <= 1, 1'b1);
      if (row.missExp != dontCare) begin
        checkFlag($sformatf("miss for %h", row.addr), missed, row.missExp[0]);
      end
      if (missed) begin
        checkAddr("memAddr_o", reqAddrSeen, {row.addr[addrWidth-1:offsetWidth], 5'b00000});
      end
      if (row.missExp == expHit) checkFlag("dataOk_o one cycle late", dataWaited == 0, 1'b1);
      prevChain = row.chain;
    end

    nextCycle();
    $display("sim passed");
    $finish;
  end

endmodule

/* test/memModel.sv */
`timescale 1ns/1ps

module memModel (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           memRdReq_i,
  input  logic [cachePkg::addrWidth-1:0] memAddr_i,
  output logic                           memRdAck_o,
  output logic                           memRdValid_o,
  output logic                           memRdLast_o,
  output logic [cachePkg::xlen-1:0]      memRdData_o
);
  import cachePkg::*;

  // scrambles the low half of every beat
  localparam logic [31:0] lowPattern = 32'hC3A5_5A3C;

  logic [31:0]          rngState;
  logic [addrWidth-1:0] lineAddr;
  int                   delay;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // byte address on top, scrambled copy below
  function automatic logic [xlen-1:0] beatData(input logic [addrWidth-1:0] a);
    return {a, a ^ lowPattern};
  endfunction

  // random delay in 0 .. range-1 cycles
  task automatic nextDelay(input int range, output int d);
    rngState = xorshift32(rngState);
    d = int'(rngState % range);
  endtask

  task automatic nextCycle();
    @(posedge clk);
    #1;
  endtask

  initial begin
    rngState = 32'd9191;
    memRdAck_o = 1'b0;
    memRdValid_o = 1'b0;
    memRdLast_o = 1'b0;
    memRdData_o = '0;
    forever begin
      nextCycle();
      if (rst_n && memRdReq_i) begin
        lineAddr = memAddr_i;
        nextDelay(6, delay);
        repeat (delay) nextCycle();
        memRdAck_o = 1'b1;
        nextCycle();
        memRdAck_o = 1'b0;
        // beats in address order, random gaps between them
        for (int beat = 0; beat < beatsPerLine; beat++) begin
          nextDelay(3, delay);
          repeat (delay) nextCycle();
          memRdValid_o = 1'b1;
          memRdLast_o = (beat == beatsPerLine - 1);
          memRdData_o = beatData(lineAddr + beat * 8);
          nextCycle();
          memRdValid_o = 1'b0;
          memRdLast_o = 1'b0;
        end
      end
    end
  end

endmodule
